//--- project.f
+incdir+verilog
+incdir+tests
verilog/controlPkg.sv
verilog/instrIntake.sv
verilog/opcodeDecoder.sv
verilog/issueSequencer.sv
verilog/controlIssue.sv
verilog/controlUnit.sv
tests/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# build and run the controlUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -sv -f project.f --top-module controlUnitTb -o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: testbench reported success"
else
    echo "run.sh: testbench reported failure"
    exit 1
fi

//--- tests/controlUnitTests.svh
// every register-class opcode comes out as one word that writes rdst
task automatic aluOps();
    logic [`CU_OPCODE_W-1:0] ops [10];
    logic [31:0] rnd;
    ops = '{`OP_NOT, `OP_INC, `OP_DEC, `OP_MOV, `OP_ADD,
            `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR};
    for (int i = 0; i < 10; i++) begin
        rnd = $urandom;
        sendWord("aluOps", makeWord(ops[i], rnd));
        expectWord("aluOps", expectSingle(ops[i], rnd[2:0], rnd[5:3]), fullMask);
    end
endtask

task automatic memAndIo();
    logic [`CU_OPCODE_W-1:0] ops [13];
    logic [31:0] rnd;
    ops = '{`OP_LDD, `OP_STD, `OP_PUSH, `OP_POP, `OP_IN, `OP_OUT, `OP_SETC,
            `OP_CLRC, `OP_JZ, `OP_JN, `OP_JC, `OP_JMP, `OP_NOP};
    for (int i = 0; i < 13; i++) begin
        rnd = $urandom;
        sendWord("memAndIo", makeWord(ops[i], rnd));
        expectWord("memAndIo", expectSingle(ops[i], rnd[2:0], rnd[5:3]), fullMask);
    end
endtask

// the second pass uses data whose top bits read as CALL, which must not be decoded
task automatic loadImmediate();
    logic [31:0] rnd;
    logic [`CU_WORD_W-1:0] data;
    ctlWord_t exp;
    for (int i = 0; i < 2; i++) begin
        rnd = $urandom;
        data = (i == 0) ? rnd[31:16] : {`OP_CALL, rnd[26:16]};
        sendWord("loadImmediate", makeWord(`OP_LDM, rnd));
        sendWord("loadImmediate", data);
        exp = '0;
        exp.aluOp = `ALU_MOV;
        exp.regWrite = 1'b1;
        exp.aluSrc = 1'b1;   // immediate stands in for rsrc
        exp.rdst = rnd[2:0];
        exp.immediate = data;
        expectWord("loadImmediate", exp, fullMask);
    end
endtask

task automatic callAndReturn();
    logic [31:0] rnd;
    logic [`CU_OPCODE_W-1:0] op;
    stallEnable = 1'b1;
    rnd = $urandom;
    sendWord("callAndReturn", makeWord(`OP_CALL, rnd));
    expectWord("callAndReturn", stackWord(`STACK_PUSH, `PHASE_FIRST, 1'b0), stackMask);
    expectWord("callAndReturn", stackWord(`STACK_PUSH, `PHASE_SECOND, 1'b0), stackMask);
    for (int k = 0; k < 2; k++) begin
        op = (k == 0) ? `OP_RET : `OP_RTI;
        sendWord("callAndReturn", makeWord(op, $urandom));
        expectWord("callAndReturn", stackWord(`STACK_POP, `PHASE_FIRST, 1'b0), stackMask);
        expectWord("callAndReturn", stackWord(`STACK_POP, `PHASE_SECOND, 1'b0), stackMask);
        sendWord("callAndReturn", makeWord(`OP_NOT, $urandom))   ;  // wrong path, dropped
        sendWord("callAndReturn", makeWord(`OP_INC, $urandom));
        rnd = $urandom;
        sendWord("callAndReturn", makeWord(`OP_SUB, rnd));   // first word past the flush
        expectWord("callAndReturn", expectSingle(`OP_SUB, rnd[2:0], rnd[5:3]), fullMask);
    end
    stallEnable = 1'b0;
endtask

task automatic interruptEntry();
    logic [31:0] rnd;
    ctlWord_t exp;
    pulseIrq();
    rnd = $urandom;
    sendWord("interruptEntry", makeWord(`OP_INC, rnd));
    expectWord("interruptEntry", stackWord(`STACK_PUSH, `PHASE_FIRST, 1'b1), stackMask);
    expectWord("interruptEntry", stackWord(`STACK_PUSH, `PHASE_SECOND, 1'b1), stackMask);
    expectWord("interruptEntry", expectSingle(`OP_INC, rnd[2:0], rnd[5:3]), fullMask);
    // the LDM head is taken one cycle after it lands, so the irq arrives in the wait state
    rnd = $urandom;
    sendWord("interruptEntry", makeWord(`OP_LDM, rnd));
    idleCycles(2);
    pulseIrq();
    sendWord("interruptEntry", rnd[31:16]);
    exp = '0;
    exp.aluOp = `ALU_MOV;
    exp.regWrite = 1'b1;
    exp.aluSrc = 1'b1;
    exp.rdst = rnd[2:0];
    exp.immediate = rnd[31:16];
    expectWord("interruptEntry", exp, fullMask);
    expectWord("interruptEntry", stackWord(`STACK_PUSH, `PHASE_FIRST, 1'b1), stackMask);
    expectWord("interruptEntry", stackWord(`STACK_PUSH, `PHASE_SECOND, 1'b1), stackMask);
endtask

// a burst sent while execute stalls at random, checked only once all words are in
task automatic backPressure();
    logic [`CU_OPCODE_W-1:0] ops [23];
    logic [`CU_OPCODE_W-1:0] op;
    logic [31:0] rnd;
    ctlWord_t expected[$];
    ops = '{`OP_NOT, `OP_INC, `OP_DEC, `OP_MOV, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR,
            `OP_SHL, `OP_SHR, `OP_PUSH, `OP_POP, `OP_LDD, `OP_STD, `OP_JZ, `OP_JN,
            `OP_JC, `OP_JMP, `OP_OUT, `OP_IN, `OP_NOP, `OP_SETC, `OP_CLRC};
    stallEnable = 1'b1;
    for (int i = 0; i < 30; i++) begin
        rnd = $urandom;
        op = ops[rnd[31:16] % 23];
        sendWord("backPressure", makeWord(op, rnd));
        expected.push_back(expectSingle(op, rnd[2:0], rnd[5:3]));
    end
    foreach (expected[i]) begin
        expectWord("backPressure", expected[i], fullMask);
    end
    stallEnable = 1'b0;
endtask

// anything still arriving now is a duplicate or a word that should have been dropped
task automatic checkDrained();
    idleCycles(20);
    if (observed.size() != 0) begin
        errors++;
        $display("[ERROR] checkDrained: expected 0 extra words, actual %0d", observed.size());
    end
endtask

//--- tests/controlUnitTb.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlUnitTb;

    // one control word as execute sees it, in the DUT's output order
    typedef struct packed {
        logic [`CU_ALU_W-1:0]  aluOp;
        logic                  regWrite, memRead, memWrite, memToReg, aluSrc;
        logic                  inPortRead, outPortWrite, setCarry, clearCarry, isShift;
        logic [1:0]            stackOp;
        logic [1:0]            stackPhase;
        logic                  intEntry;
        logic [`CU_REG_W-1:0]  rdst;
        logic [`CU_REG_W-1:0]  rsrc;
        logic [`CU_WORD_W-1:0] immediate;
    } ctlWord_t;

    logic                  clk, rstN, instrValid, instrReady, irq, ctlValid, ctlReady;
    logic [`CU_WORD_W-1:0] instrWord;
    logic [`CU_ALU_W-1:0]  aluOp;
    logic                  regWrite, memRead, memWrite, memToReg, aluSrc, intEntry;
    logic                  inPortRead, outPortWrite, setCarry, clearCarry, isShift;
    logic [1:0]            stackOp, stackPhase;
    logic [`CU_REG_W-1:0]  rdst, rsrc;
    logic [`CU_WORD_W-1:0] immediate;

    ctlWord_t observed[$];   // every word execute has taken, oldest first
    ctlWord_t sampled;
    ctlWord_t fullMask;
    ctlWord_t stackMask;     // fields that stack and interrupt words define
    int       errors;
    int       timeouts;
    bit       stallEnable;   // lets the execute side drop ready at random

    controlUnit dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1;
        ctlReady = stallEnable ? (($urandom % 4) != 0) : 1'b1;   // ready three cycles in four
    end

    // ready and valid are both settled mid-cycle, so the transfer on the next edge is certain
    always @(negedge clk) begin
        if (rstN && ctlValid && ctlReady) begin
            sampled = {aluOp, regWrite, memRead, memWrite, memToReg, aluSrc, inPortRead,
                       outPortWrite, setCarry, clearCarry, isShift, stackOp, stackPhase,
                       intEntry, rdst, rsrc, immediate};
            observed.push_back(sampled);
        end
    end

    function automatic logic [`CU_WORD_W-1:0] makeWord(input logic [`CU_OPCODE_W-1:0] op,
                                                       input logic [31:0] rnd);
        return {op, rnd[2:0], rnd[5:3], rnd[10:6]};   // random spare bits must not matter
    endfunction

    // expected word of a single-cycle instruction, built from the decode table
    function automatic ctlWord_t expectSingle(input logic [`CU_OPCODE_W-1:0] op,
                                              input logic [`CU_REG_W-1:0] rd,
                                              input logic [`CU_REG_W-1:0] rs);
        ctlWord_t e;
        e = '0;
        e.rdst = rd;
        e.rsrc = rs;
        case (op)
            `OP_NOT:  e.aluOp = `ALU_NOT;
            `OP_INC:  e.aluOp = `ALU_INC;
            `OP_DEC:  e.aluOp = `ALU_DEC;
            `OP_MOV:  e.aluOp = `ALU_MOV;
            `OP_ADD:  e.aluOp = `ALU_ADD;
            `OP_SUB:  e.aluOp = `ALU_SUB;
            `OP_AND:  e.aluOp = `ALU_AND;
            `OP_OR:   e.aluOp = `ALU_OR;
            `OP_SHL:  e.aluOp = `ALU_SHL;
            `OP_SHR:  e.aluOp = `ALU_SHR;
            `OP_LDD:  e.aluOp = `ALU_LDD;
            `OP_STD:  e.aluOp = `ALU_STD;
            `OP_JZ:   e.aluOp = `ALU_JZ;
            `OP_JN:   e.aluOp = `ALU_JN;
            `OP_JC:   e.aluOp = `ALU_JC;
            `OP_JMP:  e.aluOp = `ALU_JMP;
            `OP_SETC: e.aluOp = `ALU_SETC;
            `OP_CLRC: e.aluOp = `ALU_CLRC;
            `OP_PUSH, `OP_POP, `OP_IN, `OP_OUT: e.aluOp = `ALU_MOV;   // value just passes through
            default:  e.aluOp = `ALU_NOP;
        endcase
        e.regWrite     = op inside {`OP_NOT, `OP_INC, `OP_DEC, `OP_MOV, `OP_ADD, `OP_SUB,
                                    `OP_AND, `OP_OR, `OP_SHL, `OP_SHR, `OP_LDD, `OP_POP, `OP_IN};
        e.isShift      = op inside {`OP_SHL, `OP_SHR};
        e.memRead      = op inside {`OP_LDD, `OP_POP};
        e.memToReg     = e.memRead;
        e.memWrite     = op inside {`OP_STD, `OP_PUSH};
        e.inPortRead   = (op == `OP_IN);
        e.outPortWrite = (op == `OP_OUT);
        e.setCarry     = (op == `OP_SETC);
        e.clearCarry   = (op == `OP_CLRC);
        e.stackOp      = (op == `OP_PUSH) ? `STACK_PUSH
                                          : ((op == `OP_POP) ? `STACK_POP : `STACK_NONE);
        return e;
    endfunction

    function automatic ctlWord_t stackWord(input logic [1:0] op, input logic [1:0] phase,
                                           input logic interrupt);
        ctlWord_t e;
        e = '0;
        e.stackOp    = op;
        e.stackPhase = phase;
        e.intEntry   = interrupt;
        e.memWrite   = (op == `STACK_PUSH);   // a push writes the stack, a pop reads it
        e.memRead    = (op == `STACK_POP);
        return e;
    endfunction

    task automatic sendWord(input string testName, input logic [`CU_WORD_W-1:0] word);
        int waited;
        bit taken;
        waited = 0;
        taken = 1'b0;
        instrValid = 1'b1;
        instrWord = word;
        while (!taken && waited < 200) begin
            @(negedge clk);
            taken = instrReady;   // ready mid-cycle means the word goes on the next edge
            @(posedge clk);
            #1;
            waited++;
        end
        instrValid = 1'b0;
        if (!taken) begin
            timeouts++;
            $display("%s: fetch word %h was not accepted within 200 cycles", testName, word);
        end
    endtask

    task automatic takeWord(input string testName, output ctlWord_t word, output bit ok);
        int waited;
        waited = 0;
        while (observed.size() == 0 && waited < 200) begin
            @(posedge clk);
            #1;
            waited++;
        end
        ok = (observed.size() != 0);
        word = '0;
        if (ok) begin
            word = observed.pop_front();
        end else begin
            timeouts++;
            $display("%s: no control word came out within 200 cycles", testName);
        end
    endtask

    task automatic expectWord(input string testName, input ctlWord_t exp, input ctlWord_t mask);
        ctlWord_t act;
        bit ok;
        takeWord(testName, act, ok);
        if (ok && ((act & mask) !== (exp & mask))) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", testName, exp & mask, act & mask);
        end
    endtask

    task automatic pulseIrq();
        irq = 1'b1;
        @(posedge clk);
        #1;
        irq = 1'b0;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    `include "controlUnitTests.svh"

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instrWord = '0;
        irq = 1'b0;
        ctlReady = 1'b1;
        stallEnable = 1'b0;
        errors = 0;
        timeouts = 0;
        void'($urandom(33493));
        fullMask = '1;
        stackMask = '0;
        stackMask.regWrite = 1'b1;
        stackMask.memRead = 1'b1;
        stackMask.memWrite = 1'b1;
        stackMask.stackOp = '1;
        stackMask.stackPhase = '1;
        stackMask.intEntry = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        aluOps();
        memAndIo();
        loadImmediate();
        callAndReturn();
        interruptEntry();
        backPressure();
        checkDrained();
        $display("%0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlUnit import controlPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    output logic                   instrReady,
    input  instrWord_u             instrWord,
    input  logic                   irq,
    output logic                   ctlValid,
    input  logic                   ctlReady,
    output logic [`CU_ALU_W-1:0]   aluOp,
    output logic                   regWrite, memRead, memWrite, memToReg, aluSrc,
    output logic                   inPortRead, outPortWrite, setCarry, clearCarry, isShift,
    output logic [1:0]             stackOp,
    output logic [1:0]             stackPhase,
    output logic                   intEntry,
    output logic [`CU_REG_W-1:0]   rdst,
    output logic [`CU_REG_W-1:0]   rsrc,
    output logic [`CU_WORD_W-1:0]  immediate
);

    logic                  bufValid;
    logic                  bufTake;
    instrWord_u            bufWord;
    logic                  seqValid;
    logic                  seqReady;
    logic [`CU_ALU_W-1:0]  seqAluOp;
    logic                  seqRegWrite, seqMemRead, seqMemWrite, seqMemToReg, seqAluSrc;
    logic                  seqInPortRead, seqOutPortWrite, seqSetCarry, seqClearCarry;
    logic                  seqIsShift, seqIntEntry;
    logic [1:0]            seqStackOp;
    logic [1:0]            seqStackPhase;
    logic [`CU_REG_W-1:0]  seqRdst;
    logic [`CU_REG_W-1:0]  seqRsrc;
    logic [`CU_WORD_W-1:0] seqImmediate;

    // fetch side, one cycle of buffering
    instrIntake intake (.*);

    // decode and the multi-cycle sequences sit between the two registers
    issueSequencer sequencer (
        .clk(clk),                   .rstN(rstN),
        .irq(irq),                   .bufValid(bufValid),
        .bufWord(bufWord),           .bufTake(bufTake),
        .seqValid(seqValid),         .seqReady(seqReady),
        .aluOp(seqAluOp),            .regWrite(seqRegWrite),
        .memRead(seqMemRead),        .memWrite(seqMemWrite),
        .memToReg(seqMemToReg),      .aluSrc(seqAluSrc),
        .inPortRead(seqInPortRead),  .outPortWrite(seqOutPortWrite),
        .setCarry(seqSetCarry),      .clearCarry(seqClearCarry),
        .isShift(seqIsShift),        .stackOp(seqStackOp),
        .stackPhase(seqStackPhase),  .intEntry(seqIntEntry),
        .rdst(seqRdst),              .rsrc(seqRsrc),
        .immediate(seqImmediate)
    );

    // execute side, holds the word under back-pressure
    controlIssue issue (.*);

endmodule

//--- verilog/controlIssue.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlIssue (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   seqValid,
    output logic                   seqReady,
    input  logic [`CU_ALU_W-1:0]   seqAluOp,
    input  logic                   seqRegWrite, seqMemRead, seqMemWrite, seqMemToReg,
    input  logic                   seqAluSrc, seqInPortRead, seqOutPortWrite, seqSetCarry,
    input  logic                   seqClearCarry, seqIsShift, seqIntEntry,
    input  logic [1:0]             seqStackOp,
    input  logic [1:0]             seqStackPhase,
    input  logic [`CU_REG_W-1:0]   seqRdst,
    input  logic [`CU_REG_W-1:0]   seqRsrc,
    input  logic [`CU_WORD_W-1:0]  seqImmediate,
    output logic                   ctlValid,
    input  logic                   ctlReady,
    output logic [`CU_ALU_W-1:0]   aluOp,
    output logic                   regWrite, memRead, memWrite, memToReg,
    output logic                   aluSrc, inPortRead, outPortWrite, setCarry,
    output logic                   clearCarry, isShift, intEntry,
    output logic [1:0]             stackOp,
    output logic [1:0]             stackPhase,
    output logic [`CU_REG_W-1:0]   rdst,
    output logic [`CU_REG_W-1:0]   rsrc,
    output logic [`CU_WORD_W-1:0]  immediate
);

    // eleven flag bits, two 2-bit stack codes, two register indices
    localparam int fieldW = `CU_ALU_W + 15 + 2 * `CU_REG_W + `CU_WORD_W;

    logic [fieldW-1:0] nextWord;
    logic [fieldW-1:0] heldWord;
    logic              load;

    assign seqReady = !ctlValid || ctlReady;   // empty, or emptied on this edge
    assign load     = seqValid && seqReady;

    assign nextWord = {seqAluOp, seqRegWrite, seqMemRead, seqMemWrite, seqMemToReg,
                       seqAluSrc, seqInPortRead, seqOutPortWrite, seqSetCarry,
                       seqClearCarry, seqIsShift, seqIntEntry, seqStackOp, seqStackPhase,
                       seqRdst, seqRsrc, seqImmediate};
    assign {aluOp, regWrite, memRead, memWrite, memToReg, aluSrc, inPortRead, outPortWrite,
            setCarry, clearCarry, isShift, intEntry, stackOp, stackPhase,
            rdst, rsrc, immediate} = heldWord;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctlValid <= 1'b0;
        end else if (load) begin
            ctlValid <= 1'b1;
        end else if (ctlReady) begin
            ctlValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            heldWord <= nextWord;
        end
    end

    // execute may sample the word on any stalled cycle, so it must not move
    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        ctlValid && !ctlReady |=> ctlValid && $stable(heldWord))
        else $error("control word changed while execute stalled");

endmodule

//--- verilog/issueSequencer.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module issueSequencer import controlPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   irq,
    input  logic                   bufValid,
    input  instrWord_u             bufWord,
    output logic                   bufTake,
    output logic                   seqValid,
    input  logic                   seqReady,
    output logic [`CU_ALU_W-1:0]   aluOp,
    output logic                   regWrite, memRead, memWrite, memToReg, aluSrc,
    output logic                   inPortRead, outPortWrite, setCarry, clearCarry, isShift,
    output logic [1:0]             stackOp,
    output logic [1:0]             stackPhase,
    output logic                   intEntry,
    output logic [`CU_REG_W-1:0]   rdst,
    output logic [`CU_REG_W-1:0]   rsrc,
    output logic [`CU_WORD_W-1:0]  immediate
);

    localparam logic [2:0] sIdle       = 3'd0;
    localparam logic [2:0] sLdmWait    = 3'd1;   // head of LDM taken, data word next
    localparam logic [2:0] sCallSecond = 3'd2;
    localparam logic [2:0] sRetSecond  = 3'd3;
    localparam logic [2:0] sIntFirst   = 3'd4;
    localparam logic [2:0] sIntSecond  = 3'd5;
    localparam int flushW = $clog2(`CU_FLUSH_SLOTS + 1);

    logic [2:0]              state, nextState;
    logic                    irqPending;
    logic [flushW-1:0]       flushCnt;
    logic                    dropWord;
    logic                    useDec;
    logic [`CU_REG_W-1:0]    savedRdst;
    logic [`CU_ALU_W-1:0]    savedAlu;
    logic [`CU_OPCODE_W-1:0] decOpcode;
    logic [`CU_ALU_W-1:0]    decAluOp;
    logic                    decRegWrite, decMemRead, decMemWrite, decMemToReg, decAluSrc;
    logic                    decInPortRead, decOutPortWrite, decSetCarry, decClearCarry;
    logic                    decIsShift, decMultiCycle;
    logic [1:0]              decStackOp;

    // while LDM waits the buffer holds data, so the decoder is fed the LDM code itself
    assign decOpcode = (state == sLdmWait) ? `OP_LDM : bufWord.fields.opcode;

    opcodeDecoder decoder (
        .opcode(decOpcode),          .aluOp(decAluOp),
        .regWrite(decRegWrite),      .memRead(decMemRead),
        .memWrite(decMemWrite),      .memToReg(decMemToReg),
        .aluSrc(decAluSrc),          .inPortRead(decInPortRead),
        .outPortWrite(decOutPortWrite), .setCarry(decSetCarry),
        .clearCarry(decClearCarry),  .isShift(decIsShift),
        .stackOp(decStackOp),        .multiCycle(decMultiCycle)
    );

    // second cycles and interrupt entry are pure stack traffic
    assign useDec       = (state == sIdle) || (state == sLdmWait);
    assign aluOp        = useDec ? decAluOp : ((state == sRetSecond) ? savedAlu : `ALU_NOP);
    assign regWrite     = useDec && decRegWrite;
    assign memRead      = useDec ? decMemRead : (state == sRetSecond);
    assign memWrite     = useDec ? decMemWrite : (state != sRetSecond);
    assign memToReg     = useDec && decMemToReg;
    assign aluSrc       = useDec && decAluSrc;
    assign inPortRead   = useDec && decInPortRead;
    assign outPortWrite = useDec && decOutPortWrite;
    assign setCarry     = useDec && decSetCarry;
    assign clearCarry   = useDec && decClearCarry;
    assign isShift      = useDec && decIsShift;
    assign stackOp      = useDec ? decStackOp
                                 : ((state == sRetSecond) ? `STACK_POP : `STACK_PUSH);
    assign intEntry     = (state == sIntFirst) || (state == sIntSecond);
    assign rdst         = (state == sIdle) ? bufWord.fields.rdst : savedRdst;
    assign rsrc         = (state == sIdle) ? bufWord.fields.rsrc : '0;
    assign immediate    = (state == sLdmWait) ? bufWord.imm : '0;   // raw view of the data word

    always_comb begin
        seqValid   = 1'b0;
        bufTake    = 1'b0;
        dropWord   = 1'b0;
        stackPhase = `PHASE_NONE;
        nextState  = state;
        case (state)
            sIdle: begin
                if (irqPending) begin
                    nextState = sIntFirst;   // interrupt goes ahead of the buffered word
                end else if (bufValid && (flushCnt != '0)) begin
                    dropWord = 1'b1;   // wrong-path word behind a return
                    bufTake  = 1'b1;
                end else if (bufValid && decMultiCycle && (decStackOp == `STACK_NONE)) begin
                    bufTake   = 1'b1;   // LDM head sends nothing on its own
                    nextState = sLdmWait;
                end else if (bufValid) begin
                    seqValid = 1'b1;
                    bufTake  = seqReady;
                    if (decMultiCycle) begin
                        stackPhase = `PHASE_FIRST;
                        if (seqReady) begin
                            nextState = (decStackOp == `STACK_PUSH) ? sCallSecond : sRetSecond;
                        end
                    end
                end
            end
            sLdmWait: begin
                seqValid = bufValid;
                bufTake  = bufValid && seqReady;
                if (bufValid && seqReady) begin
                    nextState = sIdle;
                end
            end
            sIntFirst: begin
                seqValid   = 1'b1;
                stackPhase = `PHASE_FIRST;
                if (seqReady) begin
                    nextState = sIntSecond;
                end
            end
            sCallSecond, sRetSecond, sIntSecond: begin
                seqValid   = 1'b1;
                stackPhase = `PHASE_SECOND;
                if (seqReady) begin
                    nextState = sIdle;
                end
            end
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= sIdle;
            irqPending <= 1'b0;
            flushCnt   <= '0;
        end else begin
            state <= nextState;
            if (irq) begin
                irqPending <= 1'b1;
            end else if (nextState == sIntFirst) begin
                irqPending <= 1'b0;   // entry has started
            end
            if ((state == sRetSecond) && seqReady) begin
                flushCnt <= flushW'(`CU_FLUSH_SLOTS);
            end else if (dropWord) begin
                flushCnt <= flushCnt - 1'b1;
            end
        end
    end

    // rdst and ALU code survive into the second cycle or the LDM data word
    always_ff @(posedge clk) begin
        if ((state == sIdle) && bufTake) begin
            savedRdst <= bufWord.fields.rdst;
            savedAlu  <= decAluOp;
        end
    end

    // a second stack cycle only ever follows a first one, or itself under a stall
    secondAfterFirst: assert property (@(posedge clk) disable iff (!rstN)
        seqValid && (stackPhase == `PHASE_SECOND) |->
            $past(seqValid && (stackPhase != `PHASE_NONE)))
        else $error("second stack cycle without a first");

    noTakeWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        seqValid && !seqReady |-> !bufTake)
        else $error("buffer popped while the issue register is full");

endmodule

//--- verilog/opcodeDecoder.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module opcodeDecoder (
    input  logic [`CU_OPCODE_W-1:0] opcode,
    output logic [`CU_ALU_W-1:0]    aluOp,
    output logic                    regWrite, memRead, memWrite, memToReg, aluSrc,
    output logic                    inPortRead, outPortWrite, setCarry, clearCarry, isShift,
    output logic [1:0]              stackOp,
    output logic                    multiCycle   // needs more than one sequencer cycle
);

    logic aluClass;
    logic isLoad;

    // register-to-register group, every one writes rdst back
    assign aluClass = opcode inside {`OP_NOT, `OP_INC, `OP_DEC, `OP_MOV, `OP_ADD,
                                     `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR};
    assign isLoad   = (opcode == `OP_LDD) || (opcode == `OP_POP);   // data comes from memory

    always_comb begin
        case (opcode)
            `OP_NOT:  aluOp = `ALU_NOT;
            `OP_INC:  aluOp = `ALU_INC;
            `OP_DEC:  aluOp = `ALU_DEC;
            `OP_MOV:  aluOp = `ALU_MOV;
            `OP_ADD:  aluOp = `ALU_ADD;
            `OP_SUB:  aluOp = `ALU_SUB;
            `OP_AND:  aluOp = `ALU_AND;
            `OP_OR:   aluOp = `ALU_OR;
            `OP_SHL:  aluOp = `ALU_SHL;
            `OP_SHR:  aluOp = `ALU_SHR;
            `OP_LDD:  aluOp = `ALU_LDD;
            `OP_STD:  aluOp = `ALU_STD;
            `OP_CALL: aluOp = `ALU_STD;   // rdst flows to the PC as the target
            `OP_JZ:   aluOp = `ALU_JZ;
            `OP_JN:   aluOp = `ALU_JN;
            `OP_JC:   aluOp = `ALU_JC;
            `OP_JMP:  aluOp = `ALU_JMP;
            `OP_RTI:  aluOp = `ALU_RTI;
            `OP_SETC: aluOp = `ALU_SETC;
            `OP_CLRC: aluOp = `ALU_CLRC;
            // stack, port, return and LDM traffic only move a value through
            `OP_PUSH, `OP_POP, `OP_LDM, `OP_RET, `OP_IN, `OP_OUT: aluOp = `ALU_MOV;
            default:  aluOp = `ALU_NOP;   // NOP and unused codes
        endcase
    end

    assign regWrite     = aluClass || isLoad || (opcode == `OP_IN) || (opcode == `OP_LDM);
    assign memRead      = isLoad || (opcode == `OP_RET) || (opcode == `OP_RTI);
    assign memWrite     = (opcode == `OP_STD) || (opcode == `OP_PUSH) || (opcode == `OP_CALL);
    assign memToReg     = isLoad;
    assign aluSrc       = (opcode == `OP_LDM);   // the immediate replaces rsrc
    assign inPortRead   = (opcode == `OP_IN);
    assign outPortWrite = (opcode == `OP_OUT);
    assign setCarry     = (opcode == `OP_SETC);
    assign clearCarry   = (opcode == `OP_CLRC);
    assign isShift      = (opcode == `OP_SHL) || (opcode == `OP_SHR);

    always_comb begin
        if ((opcode == `OP_PUSH) || (opcode == `OP_CALL)) begin
            stackOp = `STACK_PUSH;
        end else if ((opcode == `OP_POP) || (opcode == `OP_RET) || (opcode == `OP_RTI)) begin
            stackOp = `STACK_POP;
        end else begin
            stackOp = `STACK_NONE;
        end
    end

    // LDM is the only multi-cycle opcode without a stack operation
    assign multiCycle = opcode inside {`OP_CALL, `OP_RET, `OP_RTI, `OP_LDM};

endmodule

//--- verilog/instrIntake.sv
`timescale 1ns/1ps

module instrIntake import controlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    output logic       instrReady,
    input  instrWord_u instrWord,
    output logic       bufValid,
    output instrWord_u bufWord,
    input  logic       bufTake      // sequencer consumes the held word this cycle
);

    logic accept;

    // a full buffer can still refill in the cycle it is drained
    assign instrReady = !bufValid || bufTake;
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bufValid <= 1'b0;
        end else if (accept) begin
            bufValid <= 1'b1;
        end else if (bufTake) begin
            bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bufWord <= instrWord;   // capture the fetch word as it is accepted
        end
    end

    // the sequencer must never pop an empty entry
    takeNeedsWord: assert property (@(posedge clk) disable iff (!rstN)
        bufTake |-> bufValid)
        else $error("intake popped while empty");

endmodule

//--- verilog/controlPkg.sv
`include "controlUnit_cfg.svh"

package controlPkg;

    // one fetch word, read either as an instruction or as raw data
    typedef union packed {
        struct packed {
            logic [`CU_OPCODE_W-1:0] opcode;   // top bits select the operation
            logic [`CU_REG_W-1:0]    rdst;
            logic [`CU_REG_W-1:0]    rsrc;
            // low bits carry nothing in the register formats
            logic [`CU_WORD_W-`CU_OPCODE_W-2*`CU_REG_W-1:0] spare;
        } fields;
        logic [`CU_WORD_W-1:0] imm;   // second word of LDM is taken whole
    } instrWord_u;

endpackage

//--- verilog/controlUnit_cfg.svh
`ifndef CONTROL_UNIT_CFG_SVH
`define CONTROL_UNIT_CFG_SVH

// instruction word layout
`define CU_WORD_W   16
`define CU_OPCODE_W 5
`define CU_REG_W    3
`define CU_ALU_W    5

// opcodes, in the order the ISA sheet lists them
`define OP_NOT  5'd0
`define OP_INC  5'd1
`define OP_DEC  5'd2
`define OP_MOV  5'd3
`define OP_ADD  5'd4
`define OP_SUB  5'd5
`define OP_AND  5'd6
`define OP_OR   5'd7
`define OP_SHL  5'd8
`define OP_SHR  5'd9
`define OP_PUSH 5'd10
`define OP_POP  5'd11
`define OP_LDM  5'd12   // two-word load immediate
`define OP_LDD  5'd13
`define OP_STD  5'd14
`define OP_JZ   5'd15
`define OP_JN   5'd16
`define OP_JC   5'd17
`define OP_JMP  5'd18
`define OP_CALL 5'd19
`define OP_RET  5'd20
`define OP_RTI  5'd21
`define OP_OUT  5'd22
`define OP_IN   5'd23
`define OP_NOP  5'd24
`define OP_SETC 5'd25
`define OP_CLRC 5'd26

// operation codes seen by the execute stage ALU
`define ALU_NOP  5'd0
`define ALU_NOT  5'd1
`define ALU_INC  5'd2
`define ALU_DEC  5'd3
`define ALU_MOV  5'd4
`define ALU_ADD  5'd5
`define ALU_SUB  5'd6
`define ALU_AND  5'd7
`define ALU_OR   5'd8
`define ALU_SHL  5'd9
`define ALU_SHR  5'd10
`define ALU_LDD  5'd11
`define ALU_STD  5'd12   // also passes rdst through for CALL
`define ALU_JZ   5'd13
`define ALU_JN   5'd14
`define ALU_JC   5'd15
`define ALU_JMP  5'd16
`define ALU_RTI  5'd17   // restores the frozen flags on return
`define ALU_SETC 5'd18
`define ALU_CLRC 5'd19

// stack operation and the cycle inside a two-cycle stack sequence
`define STACK_NONE   2'b00
`define STACK_PUSH   2'b01
`define STACK_POP    2'b11
`define PHASE_NONE   2'b00
`define PHASE_FIRST  2'b11
`define PHASE_SECOND 2'b01

// wrong-path words thrown away after RET or RTI
`define CU_FLUSH_SLOTS 2

`endif
